//--- cpuControlPkg.sv
package cpuControlPkg;

	// Width of the operation field at the top of the instruction
	localparam int OpcodeBits = 5;

	// Operation field values of the instruction set
	typedef enum logic [OpcodeBits-1:0] {
		opLd = 5'd0,
		opLdi = 5'd1,
		opSt = 5'd2,
		opAdd = 5'd3,
		opSub = 5'd4,
		opAnd = 5'd9,
		opOr = 5'd10,
		opAddi = 5'd11,
		opAndi = 5'd12,
		opOri = 5'd13,
		opBr = 5'd18,
		opJr = 5'd19,
		opJal = 5'd20,
		opNop = 5'd25,
		opHalt = 5'd26
	} opcodeE;

	// ALU function select as seen by the datapath
	typedef enum logic [3:0] {
		aluNone = 4'd0,
		aluSub = 4'd1,
		aluAnd = 4'd4,
		aluOr = 4'd5,
		aluAdd = 4'd15
	} aluOpE;

	// Shape of the step sequence that follows decode
	typedef enum logic [3:0] {
		classLoad,
		classLoadImm,
		classStore,
		classRegAlu,
		classImmAlu,
		classBranch,
		classJumpReg,
		classJumpLink,
		classNop,
		classHalt
	} instrClassE;

	// Control steps, fetch first and then the per-class steps
	typedef enum logic [5:0] {
		stepReset = 6'd0,
		fetch0 = 6'd1,
		fetch1 = 6'd2,
		fetch2 = 6'd3,
		decode = 6'd4,
		// Effective address, shared by ld, ldi and st
		addr1 = 6'd5,
		addr2 = 6'd6,
		ld3 = 6'd7,
		ld4 = 6'd8,
		ld5 = 6'd9,
		ldi3 = 6'd10,
		st3 = 6'd11,
		st4 = 6'd12,
		// Register and immediate ALU forms
		alu1 = 6'd13,
		alu2 = 6'd14,
		alu3 = 6'd15,
		br1 = 6'd16,
		br2 = 6'd17,
		br3 = 6'd18,
		br4 = 6'd19,
		jr1 = 6'd20,
		jal1 = 6'd21,
		jal2 = 6'd22,
		halted = 6'd63
	} stepE;

endpackage

//--- instructionDecoder.sv
`timescale 1ns/10ps

module instructionDecoder #(
	parameter int InstrWidth = 32
) (
	input logic [InstrWidth-1:0] ir,
	output cpuControlPkg::instrClassE instrClass,
	output cpuControlPkg::aluOpE aluOp
);

	cpuControlPkg::opcodeE opcode;

	// Operation field sits in the top bits of the instruction
	assign opcode = cpuControlPkg::opcodeE'(ir[InstrWidth-1 -: cpuControlPkg::OpcodeBits]);

	always_comb begin
		instrClass = cpuControlPkg::classNop;
		aluOp = cpuControlPkg::aluNone;
		case (opcode)
			cpuControlPkg::opLd: instrClass = cpuControlPkg::classLoad;
			cpuControlPkg::opLdi: instrClass = cpuControlPkg::classLoadImm;
			cpuControlPkg::opSt: instrClass = cpuControlPkg::classStore;
			cpuControlPkg::opAdd: begin
				instrClass = cpuControlPkg::classRegAlu;
				aluOp = cpuControlPkg::aluAdd;
			end
			cpuControlPkg::opSub: begin
				instrClass = cpuControlPkg::classRegAlu;
				aluOp = cpuControlPkg::aluSub;
			end
			cpuControlPkg::opAnd: begin
				instrClass = cpuControlPkg::classRegAlu;
				aluOp = cpuControlPkg::aluAnd;
			end
			cpuControlPkg::opOr: begin
				instrClass = cpuControlPkg::classRegAlu;
				aluOp = cpuControlPkg::aluOr;
			end
			cpuControlPkg::opAddi: begin
				instrClass = cpuControlPkg::classImmAlu;
				aluOp = cpuControlPkg::aluAdd;
			end
			cpuControlPkg::opAndi: begin
				instrClass = cpuControlPkg::classImmAlu;
				aluOp = cpuControlPkg::aluAnd;
			end
			cpuControlPkg::opOri: begin
				instrClass = cpuControlPkg::classImmAlu;
				aluOp = cpuControlPkg::aluOr;
			end
			cpuControlPkg::opBr: instrClass = cpuControlPkg::classBranch;
			cpuControlPkg::opJr: instrClass = cpuControlPkg::classJumpReg;
			cpuControlPkg::opJal: instrClass = cpuControlPkg::classJumpLink;
			cpuControlPkg::opHalt: instrClass = cpuControlPkg::classHalt;
			// nop and every unassigned code fall through as nop
			default: instrClass = cpuControlPkg::classNop;
		endcase
	end

endmodule

//--- stepSequencer.sv
`timescale 1ns/10ps

module stepSequencer (
	input logic Clock,
	input logic Reset,
	input logic stop,
	input cpuControlPkg::instrClassE instrClass,
	output cpuControlPkg::stepE step,
	output logic immClass
);

	cpuControlPkg::stepE stepNext;

	// Next step selection
	always_comb begin
		stepNext = step;
		if (stop) begin
			// External stop wins over everything else
			stepNext = cpuControlPkg::halted;
		end else begin
			case (step)
				cpuControlPkg::stepReset: stepNext = cpuControlPkg::fetch0;
				cpuControlPkg::fetch0: stepNext = cpuControlPkg::fetch1;
				cpuControlPkg::fetch1: stepNext = cpuControlPkg::fetch2;
				cpuControlPkg::fetch2: stepNext = cpuControlPkg::decode;
				cpuControlPkg::decode: begin
					case (instrClass)
						cpuControlPkg::classLoad,
						cpuControlPkg::classLoadImm,
						cpuControlPkg::classStore: stepNext = cpuControlPkg::addr1;
						cpuControlPkg::classRegAlu,
						cpuControlPkg::classImmAlu: stepNext = cpuControlPkg::alu1;
						cpuControlPkg::classBranch: stepNext = cpuControlPkg::br1;
						cpuControlPkg::classJumpReg: stepNext = cpuControlPkg::jr1;
						cpuControlPkg::classJumpLink: stepNext = cpuControlPkg::jal1;
						cpuControlPkg::classHalt: stepNext = cpuControlPkg::halted;
						// nop goes straight back to fetch
						default: stepNext = cpuControlPkg::fetch0;
					endcase
				end
				cpuControlPkg::addr1: stepNext = cpuControlPkg::addr2;
				// Address steps are shared, so split again on the class
				cpuControlPkg::addr2: begin
					case (instrClass)
						cpuControlPkg::classLoad: stepNext = cpuControlPkg::ld3;
						cpuControlPkg::classStore: stepNext = cpuControlPkg::st3;
						default: stepNext = cpuControlPkg::ldi3;
					endcase
				end
				cpuControlPkg::ld3: stepNext = cpuControlPkg::ld4;
				cpuControlPkg::ld4: stepNext = cpuControlPkg::ld5;
				cpuControlPkg::ld5: stepNext = cpuControlPkg::fetch0;
				cpuControlPkg::ldi3: stepNext = cpuControlPkg::fetch0;
				cpuControlPkg::st3: stepNext = cpuControlPkg::st4;
				cpuControlPkg::st4: stepNext = cpuControlPkg::fetch0;
				cpuControlPkg::alu1: stepNext = cpuControlPkg::alu2;
				cpuControlPkg::alu2: stepNext = cpuControlPkg::alu3;
				cpuControlPkg::alu3: stepNext = cpuControlPkg::fetch0;
				cpuControlPkg::br1: stepNext = cpuControlPkg::br2;
				cpuControlPkg::br2: stepNext = cpuControlPkg::br3;
				cpuControlPkg::br3: stepNext = cpuControlPkg::br4;
				cpuControlPkg::br4: stepNext = cpuControlPkg::fetch0;
				cpuControlPkg::jr1: stepNext = cpuControlPkg::fetch0;
				cpuControlPkg::jal1: stepNext = cpuControlPkg::jal2;
				cpuControlPkg::jal2: stepNext = cpuControlPkg::fetch0;
				// Only Reset leaves halted
				cpuControlPkg::halted: stepNext = cpuControlPkg::halted;
				default: stepNext = cpuControlPkg::stepReset;
			endcase
		end
	end

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			step <= cpuControlPkg::stepReset;
		end else begin
			step <= stepNext;
		end
	end

	// Immediate form flag, held for the rest of the instruction
	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			immClass <= 1'b0;
		end else if (step == cpuControlPkg::decode) begin
			immClass <= (instrClass == cpuControlPkg::classImmAlu);
		end
	end

endmodule

//--- controlSignalDecoder.sv
`timescale 1ns/10ps

module controlSignalDecoder (
	input cpuControlPkg::stepE step,
	input cpuControlPkg::aluOpE aluOp,
	input logic immClass,
	input logic conffOut,
	output logic gra,
	output logic grb,
	output logic grc,
	output logic rIn,
	output logic rOut,
	output logic mdrIn,
	output logic mdrOut,
	output logic baOut,
	output logic cOut,
	output logic zLowOut,
	output logic pcIn,
	output logic irIn,
	output logic yIn,
	output logic zIn,
	output logic pcOut,
	output logic incPc,
	output logic marIn,
	output logic read,
	output logic write,
	output logic conffIn,
	output logic run,
	output cpuControlPkg::aluOpE aluControl
);

	always_comb begin
		// Every strobe idles low, only the current step raises its own
		gra = 1'b0;
		grb = 1'b0;
		grc = 1'b0;
		rIn = 1'b0;
		rOut = 1'b0;
		mdrIn = 1'b0;
		mdrOut = 1'b0;
		baOut = 1'b0;
		cOut = 1'b0;
		zLowOut = 1'b0;
		pcIn = 1'b0;
		irIn = 1'b0;
		yIn = 1'b0;
		zIn = 1'b0;
		pcOut = 1'b0;
		incPc = 1'b0;
		marIn = 1'b0;
		read = 1'b0;
		write = 1'b0;
		conffIn = 1'b0;
		run = 1'b1;
		aluControl = cpuControlPkg::aluNone;

		case (step)
			// PC to MAR, incremented PC into Z
			cpuControlPkg::fetch0: begin
				pcOut = 1'b1;
				marIn = 1'b1;
				incPc = 1'b1;
				zIn = 1'b1;
			end
			cpuControlPkg::fetch1: begin
				zLowOut = 1'b1;
				pcIn = 1'b1;
				read = 1'b1;
				mdrIn = 1'b1;
			end
			cpuControlPkg::fetch2: begin
				mdrOut = 1'b1;
				irIn = 1'b1;
			end
			// Base register (or zero) into Y, then add the constant
			cpuControlPkg::addr1: begin
				grb = 1'b1;
				baOut = 1'b1;
				yIn = 1'b1;
			end
			cpuControlPkg::addr2: begin
				cOut = 1'b1;
				zIn = 1'b1;
				aluControl = cpuControlPkg::aluAdd;
			end
			cpuControlPkg::ld3, cpuControlPkg::st3: begin
				zLowOut = 1'b1;
				marIn = 1'b1;
			end
			cpuControlPkg::ld4: begin
				mdrIn = 1'b1;
				read = 1'b1;
			end
			cpuControlPkg::ld5: begin
				mdrOut = 1'b1;
				gra = 1'b1;
				rIn = 1'b1;
			end
			// Result write-back from Z, shared by ldi and the ALU forms
			cpuControlPkg::ldi3, cpuControlPkg::alu3: begin
				zLowOut = 1'b1;
				gra = 1'b1;
				rIn = 1'b1;
			end
			cpuControlPkg::st4: begin
				gra = 1'b1;
				rOut = 1'b1;
				mdrIn = 1'b1;
				write = 1'b1;
			end
			cpuControlPkg::alu1: begin
				grb = 1'b1;
				rOut = 1'b1;
				yIn = 1'b1;
			end
			// Second operand is Rc or the immediate constant
			cpuControlPkg::alu2: begin
				zIn = 1'b1;
				aluControl = aluOp;
				if (immClass) begin
					cOut = 1'b1;
				end else begin
					grc = 1'b1;
					rOut = 1'b1;
				end
			end
			cpuControlPkg::br1: begin
				gra = 1'b1;
				rOut = 1'b1;
				conffIn = 1'b1;
			end
			cpuControlPkg::br2: begin
				pcOut = 1'b1;
				yIn = 1'b1;
			end
			cpuControlPkg::br3: begin
				cOut = 1'b1;
				zIn = 1'b1;
				aluControl = cpuControlPkg::aluAdd;
			end
			// Target is loaded only when the condition held
			cpuControlPkg::br4: begin
				zLowOut = 1'b1;
				pcIn = conffOut;
			end
			cpuControlPkg::jr1, cpuControlPkg::jal2: begin
				gra = 1'b1;
				rOut = 1'b1;
				pcIn = 1'b1;
			end
			cpuControlPkg::jal1: begin
				grb = 1'b1;
				rIn = 1'b1;
				pcOut = 1'b1;
			end
			cpuControlPkg::halted: run = 1'b0;
			// stepReset and decode drive nothing
			default: ;
		endcase
	end

endmodule

//--- controlUnit.sv
`timescale 1ns/10ps

module controlUnit #(
	parameter int InstrWidth = 32
) (
	input logic Clock,
	input logic Reset,
	input logic [InstrWidth-1:0] ir,
	input logic stop,
	input logic conffOut,
	output logic gra,
	output logic grb,
	output logic grc,
	output logic rIn,
	output logic rOut,
	output logic mdrIn,
	output logic mdrOut,
	output logic baOut,
	output logic cOut,
	output logic zLowOut,
	output logic pcIn,
	output logic irIn,
	output logic yIn,
	output logic zIn,
	output logic pcOut,
	output logic incPc,
	output logic marIn,
	output logic read,
	output logic write,
	output logic conffIn,
	output logic run,
	output cpuControlPkg::aluOpE aluControl
);

	cpuControlPkg::instrClassE instrClass;
	cpuControlPkg::aluOpE aluOp;
	cpuControlPkg::stepE step;
	logic immClass;

	instructionDecoder #(
		.InstrWidth(InstrWidth)
	) decoder (
		.ir(ir),
		.instrClass(instrClass),
		.aluOp(aluOp)
	);

	stepSequencer sequencer (
		.Clock(Clock),
		.Reset(Reset),
		.stop(stop),
		.instrClass(instrClass),
		.step(step),
		.immClass(immClass)
	);

	// Per-step strobe table
	controlSignalDecoder strobes (
		.step(step),
		.aluOp(aluOp),
		.immClass(immClass),
		.conffOut(conffOut),
		.gra(gra),
		.grb(grb),
		.grc(grc),
		.rIn(rIn),
		.rOut(rOut),
		.mdrIn(mdrIn),
		.mdrOut(mdrOut),
		.baOut(baOut),
		.cOut(cOut),
		.zLowOut(zLowOut),
		.pcIn(pcIn),
		.irIn(irIn),
		.yIn(yIn),
		.zIn(zIn),
		.pcOut(pcOut),
		.incPc(incPc),
		.marIn(marIn),
		.read(read),
		.write(write),
		.conffIn(conffIn),
		.run(run),
		.aluControl(aluControl)
	);

endmodule

//--- controlUnit_sva.sv
`timescale 1ns/10ps

module controlUnitSva (
	input logic Clock,
	input logic Reset,
	input logic read,
	input logic write,
	input logic pcIn,
	input logic run,
	input cpuControlPkg::stepE step
);

	// Count of failed assertions
	int failCount = 0;

	// Memory is either read or written in a step, never both
	readWriteExclusive: assert property (@(posedge Clock) disable iff (Reset) !(read && write))
	else begin
		failCount++;
		$error("read and write high in the same cycle");
	end

	// PC is loaded by fetch1 and by the jump and branch steps only
	pcInOnlyWhenLoading: assert property (@(posedge Clock) disable iff (Reset)
		pcIn |-> step inside {cpuControlPkg::fetch1, cpuControlPkg::br4,
			cpuControlPkg::jr1, cpuControlPkg::jal2})
	else begin
		failCount++;
		$error("pcIn high outside a PC load step");
	end

	// Halted is left only through Reset
	runStaysLow: assert property (@(posedge Clock) disable iff (Reset) !run |=> !run)
	else begin
		failCount++;
		$error("run rose again without Reset");
	end

endmodule

bind controlUnit controlUnitSva sva (
	.Clock(Clock),
	.Reset(Reset),
	.read(read),
	.write(write),
	.pcIn(pcIn),
	.run(run),
	.step(step)
);

//--- controlUnitTb.sv
`timescale 1ns/10ps

module controlUnitTb;

	localparam int InstrWidth = 32;
	localparam int VecCount = 16;
	localparam int VecFields = 8;
	localparam int FetchTimeout = 20;

	// Strobe words of the steps that every instruction shares
	localparam logic [31:0] WordReset = 32'h0000010;
	localparam logic [31:0] WordFetch0 = 32'h0000F10;
	localparam logic [31:0] WordFetch1 = 32'h008C090;
	localparam logic [31:0] WordFetch2 = 32'h0042010;
	localparam logic [31:0] WordDecode = 32'h0000010;
	localparam logic [31:0] WordHalted = 32'h0000000;
	// Effective address steps of ld
	localparam logic [31:0] WordAddr1 = 32'h0821010;
	localparam logic [31:0] WordAddr2 = 32'h001081F;

	logic Clock;
	logic Reset;
	logic stop;
	logic conffOut;
	logic [InstrWidth-1:0] ir;
	logic gra, grb, grc, rIn, rOut, mdrIn, mdrOut, baOut, cOut, zLowOut;
	logic pcIn, irIn, yIn, zIn, pcOut, incPc, marIn, read, write, conffIn, run;
	cpuControlPkg::aluOpE aluControl;

	logic [31:0] vecMem [0:VecCount*VecFields-1];
	int seed;
	int errorCount;
	int testCount;
	int failedTests;

	controlUnit #(
		.InstrWidth(InstrWidth)
	) UUT (
		.Clock(Clock), .Reset(Reset), .ir(ir), .stop(stop), .conffOut(conffOut),
		.gra(gra), .grb(grb), .grc(grc), .rIn(rIn), .rOut(rOut),
		.mdrIn(mdrIn), .mdrOut(mdrOut), .baOut(baOut), .cOut(cOut),
		.zLowOut(zLowOut), .pcIn(pcIn), .irIn(irIn), .yIn(yIn), .zIn(zIn),
		.pcOut(pcOut), .incPc(incPc), .marIn(marIn), .read(read), .write(write),
		.conffIn(conffIn), .run(run), .aluControl(aluControl)
	);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	// Strobes in datapath order, then run and the ALU select
	function automatic logic [31:0] strobeWord();
		return {7'd0, gra, grb, grc, rIn, rOut, mdrIn, mdrOut, baOut, cOut, zLowOut,
			pcIn, irIn, yIn, zIn, pcOut, incPc, marIn, read, write, conffIn, run,
			4'(aluControl)};
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERR %s: got %h, expected %h", name, actual, expected);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int startErrors);
		testCount++;
		if (errorCount == startErrors) begin
			$display("Test %s: ok", name);
		end else begin
			failedTests++;
			$display("Test %s: %0d errors", name, errorCount - startErrors);
		end
	endtask

	// Called on a falling edge, returns on the falling edge after release
	task automatic applyReset();
		Reset = 1'b1;
		repeat (3) @(negedge Clock);
		Reset = 1'b0;
	endtask

	task automatic waitForFetch(input int limit);
		int waited;
		waited = 0;
		while (strobeWord() !== WordFetch0 && waited < limit) begin
			@(negedge Clock);
			waited++;
		end
		if (strobeWord() !== WordFetch0) begin
			$display("Timeout: fetch0 was not reached within %0d cycles", limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	endtask

	// From fetch0 through decode, ir held stable from here on
	task automatic startInstruction(input logic [4:0] opcode, input logic cond);
		logic [31:0] randBits;
		checkValue("strobes fetch0", strobeWord(), WordFetch0);
		randBits = $random(seed);
		ir = {opcode, randBits[InstrWidth-6:0]};
		conffOut = cond;
		@(negedge Clock);
		checkValue("strobes fetch1", strobeWord(), WordFetch1);
		@(negedge Clock);
		checkValue("strobes fetch2", strobeWord(), WordFetch2);
		@(negedge Clock);
		checkValue("strobes decode", strobeWord(), WordDecode);
	endtask

	task automatic runVector(input int idx);
		int base;
		int count;
		int startErrors;
		logic [4:0] opcode;
		logic cond;
		base = idx * VecFields;
		opcode = vecMem[base][4:0];
		cond = vecMem[base+1][0];
		count = vecMem[base+2];
		startErrors = errorCount;
		waitForFetch(FetchTimeout);
		startInstruction(opcode, cond);
		for (int s = 0; s < count; s++) begin
			@(negedge Clock);
			checkValue($sformatf("strobes step %0d", s + 1), strobeWord(), vecMem[base+3+s]);
		end
		@(negedge Clock);
		checkValue("strobes next fetch0", strobeWord(), WordFetch0);
		reportTest($sformatf("opcode %h conffOut %0d", opcode, cond), startErrors);
	endtask

	task automatic runHalt();
		int startErrors;
		startErrors = errorCount;
		waitForFetch(FetchTimeout);
		startInstruction(5'h1A, 1'b0);
		repeat (20) begin
			@(negedge Clock);
			checkValue("strobes halted", strobeWord(), WordHalted);
		end
		applyReset();
		checkValue("strobes reset", strobeWord(), WordReset);
		@(negedge Clock);
		checkValue("strobes fetch0 after reset", strobeWord(), WordFetch0);
		reportTest("halt", startErrors);
	endtask

	// Stop raised during addr2 of an ld
	task automatic runStop();
		int startErrors;
		startErrors = errorCount;
		waitForFetch(FetchTimeout);
		startInstruction(5'h00, 1'b0);
		@(negedge Clock);
		checkValue("strobes addr1", strobeWord(), WordAddr1);
		@(negedge Clock);
		checkValue("strobes addr2", strobeWord(), WordAddr2);
		stop = 1'b1;
		@(negedge Clock);
		checkValue("run after stop", 32'(run), 32'h0);
		stop = 1'b0;
		repeat (10) begin
			@(negedge Clock);
			checkValue("strobes halted", strobeWord(), WordHalted);
		end
		applyReset();
		checkValue("strobes reset", strobeWord(), WordReset);
		@(negedge Clock);
		checkValue("strobes fetch0 after reset", strobeWord(), WordFetch0);
		reportTest("stop", startErrors);
	endtask

	initial begin
		int startErrors;
		seed = 32'h997c3100;
		errorCount = 0;
		testCount = 0;
		failedTests = 0;
		Reset = 1'b1;
		stop = 1'b0;
		conffOut = 1'b0;
		ir = '0;
		$readmemh("controlVectors.txt", vecMem);
		if ($isunknown(vecMem[VecCount*VecFields-1])) begin
			$display("Vector file controlVectors.txt could not be read completely");
			errorCount++;
		end else begin
			startErrors = errorCount;
			applyReset();
			checkValue("strobes reset", strobeWord(), WordReset);
			@(negedge Clock);
			reportTest("reset", startErrors);
			for (int v = 0; v < VecCount; v++) begin
				runVector(v);
			end
			runHalt();
			runStop();
		end
		$display("Tests: %0d run, %0d failed, %0d check errors, %0d assertion failures",
			testCount, failedTests, errorCount, UUT.sva.failCount);
		if (errorCount == 0 && UUT.sva.failCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- controlVectors.txt
// opcode conffOut stepCount word1 word2 word3 word4 word5, all hex
// word bits: gra grb grc rIn rOut mdrIn mdrOut baOut cOut zLowOut pcIn irIn yIn zIn
//            pcOut incPc marIn read write conffIn run aluControl[3:0]
00 0 5 0821010 001081F 0008110 0080090 1240010 // ld
01 0 3 0821010 001081F 1208010 0000000 0000000 // ldi
02 0 4 0821010 001081F 0008110 1180050 0000000 // st
03 0 3 0901010 050081F 1208010 0000000 0000000 // add
04 0 3 0901010 0500811 1208010 0000000 0000000 // sub
09 0 3 0901010 0500814 1208010 0000000 0000000 // and
0A 0 3 0901010 0500815 1208010 0000000 0000000 // or
0B 0 3 0901010 001081F 1208010 0000000 0000000 // addi
0C 0 3 0901010 0010814 1208010 0000000 0000000 // andi
0D 0 3 0901010 0010815 1208010 0000000 0000000 // ori
12 0 4 1100030 0001410 001081F 0008010 0000000 // br, not taken
12 1 4 1100030 0001410 001081F 000C010 0000000 // br, taken
13 0 1 1104010 0000000 0000000 0000000 0000000 // jr
14 0 2 0A00410 1104010 0000000 0000000 0000000 // jal
19 0 0 0000000 0000000 0000000 0000000 0000000 // nop
1F 0 0 0000000 0000000 0000000 0000000 0000000 // unknown opcode

//--- list.f
cpuControlPkg.sv
instructionDecoder.sv
stepSequencer.sv
controlSignalDecoder.sv
controlUnit.sv
controlUnit_sva.sv
controlUnitTb.sv

//--- Bender.yml
package:
  name: control_unit

sources:
  - cpuControlPkg.sv
  - instructionDecoder.sv
  - stepSequencer.sv
  - controlSignalDecoder.sv
  - controlUnit.sv
  - target: simulation
    files:
      - controlUnit_sva.sv
      - controlUnitTb.sv
